//--- build.f
source/mldsa_params_pkg.sv
source/skdecode_pkg.sv
source/skdecode_stream_if.sv
source/s1s2_unpack_lane.sv
source/sk_beat_receiver.sv
source/coeff_mem_writer.sv
source/skdecode_s1s2_top.sv
tests/skdecode_s1s2_tb.sv

//--- source/coeff_mem_writer.sv
// Coefficient memory writer. It accepts a bundle of lane results and writes it
// as consecutive memory words, four coefficients each, while counting addresses.
// It raises done after the last word and latches a sticky key error until start.

`timescale 1ns/1ps

module coeff_mem_writer (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    start_i,
    skdecode_stream_if.dst          result_i,
    output logic                    mem_we_o,
    output skdecode_pkg::mem_addr_t mem_addr_o,
    output skdecode_pkg::mem_word_t mem_wdata_o,
    output logic                    done_o,
    output logic                    error_o
);

    logic                                            busy_q;
    logic [$clog2(skdecode_pkg::words_per_beat)-1:0] word_q;
    skdecode_pkg::mem_addr_t                         addr_q;
    logic                                            done_q;
    logic                                            error_q;
    skdecode_pkg::lane_bundle_t                      bundle_q;
    logic                                            accept;
    logic                                            beat_error;
    logic                                            last_word;

    // only an idle writer takes a beat, so at most one bundle is held here
    // start takes priority, so nothing is accepted in the start cycle
    assign result_i.ready  = !busy_q && !start_i;
    assign result_i.status = error_q;
    assign accept          = result_i.valid && result_i.ready;

    // one bad field spoils the whole beat
    always_comb begin
        beat_error = 1'b0;
        for (int i = 0; i < skdecode_pkg::num_lanes; i++) begin
            beat_error = beat_error | result_i.payload[i].error;
        end
    end

    assign last_word = (word_q == ($bits(word_q))'(skdecode_pkg::words_per_beat - 1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            word_q  <= '0;
            addr_q  <= '0;
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else if (start_i) begin
            // a new run restarts at address 0 with both flags cleared
            busy_q  <= 1'b0;
            word_q  <= '0;
            addr_q  <= '0;
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else if (busy_q) begin
            // every busy cycle writes one word
            addr_q <= addr_q + 1'b1;
            if (addr_q == skdecode_pkg::mem_addr_t'(skdecode_pkg::total_words - 1)) begin
                done_q <= 1'b1;
            end
            if (last_word) begin
                busy_q <= 1'b0;
                word_q <= '0;
            end else begin
                word_q <= word_q + 1'b1;
            end
        end else if (accept) begin
            // an errored beat is dropped and halts the run
            // beats after an error or after done are taken and discarded
            if (beat_error) begin
                error_q <= 1'b1;
            end else if (!error_q && !done_q) begin
                busy_q <= 1'b1;
            end
        end
    end

    // payload register, qualified by busy_q
    always_ff @(posedge clk) begin
        if (accept) begin
            bundle_q <= result_i.payload;
        end
    end

    // word_q selects which group of lanes goes out, coefficient 0 in the low bits
    always_comb begin
        for (int j = 0; j < skdecode_pkg::coeffs_per_word; j++) begin
            mem_wdata_o[j*mldsa_params_pkg::reg_size +: mldsa_params_pkg::reg_size] =
                bundle_q[int'(word_q)*skdecode_pkg::coeffs_per_word + j].coeff;
        end
    end

    assign mem_we_o   = busy_q;
    assign mem_addr_o = addr_q;
    assign done_o     = done_q;
    assign error_o    = error_q;

endmodule

//--- source/mldsa_params_pkg.sv
// ML-DSA-87 algorithm constants used by the secret-key s1/s2 decode path.
// Referenced by scoped name from the decoder package, the RTL and the testbench.

package mldsa_params_pkg;

    // prime modulus of the ring, all coefficients live in [0, q-1]
    localparam int unsigned mldsa_q = 8380417;

    // ML-DSA-87 uses eta = 2, so packed values run from 0 to 2*eta
    localparam int unsigned mldsa_eta = 2;

    // bits per packed eta field, bitlen(2*eta)
    localparam int unsigned eta_size = 3;

    // bits per stored coefficient, wide enough for any value below q
    localparam int unsigned reg_size = 24;

    // coefficients per polynomial
    localparam int unsigned mldsa_n = 256;

    // s1 holds L polynomials and s2 holds K polynomials
    localparam int unsigned mldsa_l = 7;
    localparam int unsigned mldsa_k = 8;

endpackage

//--- source/s1s2_unpack_lane.sv
// One unpack lane, which turns a packed eta field into its s1/s2 coefficient.
// The coefficient is eta minus the field value, reduced mod q. Fields above 2*eta are errors.

`timescale 1ns/1ps

module s1s2_unpack_lane (
    input  skdecode_pkg::eta_field_t   field_i,
    output skdecode_pkg::lane_result_t result_o
);

    always_comb begin
        result_o = '0;

        if (field_i > skdecode_pkg::eta_field_t'(2 * mldsa_params_pkg::mldsa_eta)) begin
            // values 5 to 7 cannot come from a valid key
            // the coefficient stays 0 and only the error bit is set
            result_o.error = 1'b1;
        end else if (field_i <= skdecode_pkg::eta_field_t'(mldsa_params_pkg::mldsa_eta)) begin
            // 0, 1 and 2 give the non-negative results 2, 1 and 0
            result_o.coeff = skdecode_pkg::coeff_t'(mldsa_params_pkg::mldsa_eta) -
                             skdecode_pkg::coeff_t'(field_i);
        end else begin
            // 3 and 4 give -1 and -2, which wrap to q-1 and q-2
            result_o.coeff = skdecode_pkg::coeff_t'(mldsa_params_pkg::mldsa_q +
                                                    mldsa_params_pkg::mldsa_eta) -
                             skdecode_pkg::coeff_t'(field_i);
        end
    end

endmodule

//--- source/sk_beat_receiver.sv
// Four-phase req/ack receiver for packed secret-key beats.
// Each captured beat is split into its eta fields and offered on the field stream.

`timescale 1ns/1ps

module sk_beat_receiver (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   sk_req_i,
    input  skdecode_pkg::sk_beat_t sk_data_i,
    output logic                   sk_ack_o,
    skdecode_stream_if.src         field_o
);

    // the handshake only needs to know whether ack is currently raised
    typedef enum logic {
        HS_IDLE,
        HS_ACK
    } hs_state_e;

    hs_state_e              hs_state_q;
    logic                   req_q;
    logic                   valid_q;
    skdecode_pkg::sk_beat_t beat_q;
    logic                   capture;

    // req comes from another domain, so it is only looked at after one register
    // a new beat is taken only when the previous one has left or leaves on this edge
    assign capture = (hs_state_q == HS_IDLE) && req_q && (!valid_q || field_o.ready);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q      <= 1'b0;
            hs_state_q <= HS_IDLE;
            valid_q    <= 1'b0;
        end else begin
            req_q <= sk_req_i;

            case (hs_state_q)
                HS_IDLE: begin
                    // ack rises together with the capture
                    if (capture) begin
                        hs_state_q <= HS_ACK;
                    end
                end
                HS_ACK: begin
                    // ack falls one cycle after req is seen low
                    if (!req_q) begin
                        hs_state_q <= HS_IDLE;
                    end
                end
                default: hs_state_q <= HS_IDLE;
            endcase

            // once the sink has halted, beats are acked but never offered
            if (capture) begin
                valid_q <= !field_o.status;
            end else if (field_o.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    // the beat register needs no reset since valid qualifies it
    always_ff @(posedge clk) begin
        if (capture) begin
            beat_q <= sk_data_i;
        end
    end

    // field i is taken from bits 3i upward, in field order
    always_comb begin
        for (int i = 0; i < skdecode_pkg::num_lanes; i++) begin
            field_o.payload[i] = beat_q[i*mldsa_params_pkg::eta_size +: mldsa_params_pkg::eta_size];
        end
    end

    assign field_o.valid = valid_q;
    assign sk_ack_o      = (hs_state_q == HS_ACK);

endmodule

//--- source/skdecode_pkg.sv
// Structural constants and data types of the s1/s2 decoder.
// Widths derive from the algorithm constants, so both packages must compile in order.

package skdecode_pkg;

    // one packed beat carries this many eta fields
    localparam int unsigned num_lanes = 8;

    // coefficients packed into one memory word, lowest lane in the lowest bits
    localparam int unsigned coeffs_per_word = 4;
    localparam int unsigned words_per_beat = num_lanes / coeffs_per_word;

    // all L+K polynomials, 960 words for ML-DSA-87
    localparam int unsigned total_words =
        (mldsa_params_pkg::mldsa_l + mldsa_params_pkg::mldsa_k) *
        mldsa_params_pkg::mldsa_n / coeffs_per_word;
    localparam int unsigned addr_width = 10;

    typedef logic [mldsa_params_pkg::eta_size-1:0] eta_field_t;
    typedef logic [mldsa_params_pkg::reg_size-1:0] coeff_t;

    // field i sits in bits 3i to 3i+2
    typedef logic [num_lanes*mldsa_params_pkg::eta_size-1:0] sk_beat_t;

    // one lane output, the error bit marks a field above 2*eta
    typedef struct packed {
        coeff_t coeff;
        logic   error;
    } lane_result_t;

    typedef lane_result_t [num_lanes-1:0] lane_bundle_t;
    typedef eta_field_t [num_lanes-1:0] field_bundle_t;

    typedef logic [coeffs_per_word*mldsa_params_pkg::reg_size-1:0] mem_word_t;
    typedef logic [addr_width-1:0] mem_addr_t;

endpackage

//--- source/skdecode_s1s2_top.sv
// Top of the s1/s2 secret-key decode path with plain ports only.
// Beats enter over four-phase req/ack and leave as 96-bit coefficient memory writes.

`timescale 1ns/1ps

module skdecode_s1s2_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    start_i,
    input  logic                    sk_req_i,
    input  skdecode_pkg::sk_beat_t  sk_data_i,
    output logic                    sk_ack_o,
    output logic                    mem_we_o,
    output skdecode_pkg::mem_addr_t mem_addr_o,
    output skdecode_pkg::mem_word_t mem_wdata_o,
    output logic                    done_o,
    output logic                    error_o
);

    // raw fields from the receiver, then decoded lane results for the writer
    skdecode_stream_if #(.payload_t(skdecode_pkg::field_bundle_t)) field_s ();
    skdecode_stream_if #(.payload_t(skdecode_pkg::lane_bundle_t)) result_s ();

    skdecode_pkg::lane_result_t lane_res [skdecode_pkg::num_lanes];

    sk_beat_receiver u_receiver (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .sk_req_i (sk_req_i),
        .sk_data_i(sk_data_i),
        .sk_ack_o (sk_ack_o),
        .field_o  (field_s)
    );

    // the lanes add no delay, so handshake and status go straight across
    assign result_s.valid = field_s.valid;
    assign field_s.ready  = result_s.ready;
    assign field_s.status = result_s.status;

    // one lane per packed field
    for (genvar g = 0; g < skdecode_pkg::num_lanes; g++) begin : g_lane
        s1s2_unpack_lane u_lane (
            .field_i (field_s.payload[g]),
            .result_o(lane_res[g])
        );
    end

    always_comb begin
        for (int i = 0; i < skdecode_pkg::num_lanes; i++) begin
            result_s.payload[i] = lane_res[i];
        end
    end

    coeff_mem_writer u_writer (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (start_i),
        .result_i   (result_s),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_wdata_o(mem_wdata_o),
        .done_o     (done_o),
        .error_o    (error_o)
    );

endmodule

//--- source/skdecode_stream_if.sv
// Valid/ready stream between the decoder blocks, with the payload type as a parameter.
// The source holds payload stable while valid is high and ready is low.

`timescale 1ns/1ps

interface skdecode_stream_if #(
    parameter type payload_t = logic
);

    // a transfer happens on a clock edge where valid and ready are both high
    logic     valid;
    logic     ready;
    payload_t payload;

    // status runs from the sink back to the source
    // it is high while the sink has halted on a key error and drops every beat
    logic     status;

    modport src (
        output valid,
        output payload,
        input  ready,
        input  status
    );

    modport dst (
        input  valid,
        input  payload,
        output ready,
        output status
    );

endinterface

//--- tests/skdecode_s1s2_tb.sv
// Testbench for the s1/s2 secret-key decode top level.
// Drives four-phase beats from a directed table and from an xorshift source,
// watches every memory write against a queue of expected words and checks the handshake.

`timescale 1ns/1ps

module skdecode_s1s2_tb;

    localparam int num_directed = 5;
    localparam int num_random = 480;
    // directed, random, error phase and restart beats
    localparam int planned_beats = num_directed + num_random + 6 + 1;
    localparam int watchdog_cycles = planned_beats * 20 + 200;

    // expected coefficients for field values 0 to 4, eta minus the field mod q
    localparam skdecode_pkg::coeff_t c_p2 = skdecode_pkg::coeff_t'(2);
    localparam skdecode_pkg::coeff_t c_p1 = skdecode_pkg::coeff_t'(1);
    localparam skdecode_pkg::coeff_t c_z = skdecode_pkg::coeff_t'(0);
    localparam skdecode_pkg::coeff_t c_m1 = skdecode_pkg::coeff_t'(mldsa_params_pkg::mldsa_q - 1);
    localparam skdecode_pkg::coeff_t c_m2 = skdecode_pkg::coeff_t'(mldsa_params_pkg::mldsa_q - 2);

    // one directed beat, the cycles req stays up after ack, and both expected words
    typedef struct packed {
        skdecode_pkg::sk_beat_t  beat;
        logic [1:0]              hold;
        skdecode_pkg::mem_word_t word_lo;
        skdecode_pkg::mem_word_t word_hi;
    } dir_row_t;

    logic                    clk;
    logic                    rst_n_i;
    logic                    start_i;
    logic                    sk_req_i;
    skdecode_pkg::sk_beat_t  sk_data_i;
    logic                    sk_ack_o;
    logic                    mem_we_o;
    skdecode_pkg::mem_addr_t mem_addr_o;
    skdecode_pkg::mem_word_t mem_wdata_o;
    logic                    done_o;
    logic                    error_o;

    dir_row_t                dir_table [num_directed];
    skdecode_pkg::mem_word_t exp_word_q [$];
    skdecode_pkg::mem_addr_t exp_addr_q [$];
    logic [31:0]             rng_state;
    logic                    ack_prev;

    skdecode_s1s2_top dut (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (start_i),
        .sk_req_i   (sk_req_i),
        .sk_data_i  (sk_data_i),
        .sk_ack_o   (sk_ack_o),
        .mem_we_o   (mem_we_o),
        .mem_addr_o (mem_addr_o),
        .mem_wdata_o(mem_wdata_o),
        .done_o     (done_o),
        .error_o    (error_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        stop_on_failure();
    endtask

    task automatic check_word(input string name, input skdecode_pkg::mem_word_t got,
                              input skdecode_pkg::mem_word_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input string name, input skdecode_pkg::mem_addr_t got,
                              input skdecode_pkg::mem_addr_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // 32-bit xorshift with the 13/17/5 shift triple
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // eta minus the field value, brought back into [0, q-1]
    function automatic skdecode_pkg::coeff_t coeff_of(input int v);
        int c;
        c = int'(mldsa_params_pkg::mldsa_eta) - v;
        if (c < 0) begin
            c = c + int'(mldsa_params_pkg::mldsa_q);
        end
        return skdecode_pkg::coeff_t'(c);
    endfunction

    // half 0 covers lanes 0 to 3 and half 1 lanes 4 to 7, lowest lane in the low bits
    function automatic skdecode_pkg::mem_word_t word_from_beat(input skdecode_pkg::sk_beat_t beat,
                                                               input int half);
        skdecode_pkg::mem_word_t w;
        int                      lane;
        w = '0;
        for (int j = 0; j < skdecode_pkg::coeffs_per_word; j++) begin
            lane = half * skdecode_pkg::coeffs_per_word + j;
            w[j*mldsa_params_pkg::reg_size +: mldsa_params_pkg::reg_size] =
                coeff_of(int'(beat[lane*mldsa_params_pkg::eta_size +: mldsa_params_pkg::eta_size]));
        end
        return w;
    endfunction

    // every lane position sees each value 0 to 4 across the five rows
    task automatic fill_table();
        dir_table[0] = '{{3'd2, 3'd1, 3'd0, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0}, 2'd0,
                         {c_m1, c_z, c_p1, c_p2}, {c_z, c_p1, c_p2, c_m2}};
        dir_table[1] = '{{3'd3, 3'd2, 3'd1, 3'd0, 3'd4, 3'd3, 3'd2, 3'd1}, 2'd1,
                         {c_m2, c_m1, c_z, c_p1}, {c_m1, c_z, c_p1, c_p2}};
        dir_table[2] = '{{3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd4, 3'd3, 3'd2}, 2'd2,
                         {c_p2, c_m2, c_m1, c_z}, {c_m2, c_m1, c_z, c_p1}};
        dir_table[3] = '{{3'd0, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd4, 3'd3}, 2'd3,
                         {c_p1, c_p2, c_m2, c_m1}, {c_p2, c_m2, c_m1, c_z}};
        dir_table[4] = '{{3'd1, 3'd0, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd4}, 2'd0,
                         {c_z, c_p1, c_p2, c_m2}, {c_p1, c_p2, c_m2, c_m1}};
    endtask

    // each field is a random value mod 5, so the beat is always a valid key beat
    task automatic random_beat(output skdecode_pkg::sk_beat_t beat);
        beat = '0;
        for (int i = 0; i < skdecode_pkg::num_lanes; i++) begin
            rng_state = xorshift32(rng_state);
            beat[i*mldsa_params_pkg::eta_size +: mldsa_params_pkg::eta_size] =
                skdecode_pkg::eta_field_t'(rng_state % 5);
        end
    endtask

    task automatic random_hold(output int hold);
        rng_state = xorshift32(rng_state);
        hold = int'(rng_state % 4);
    endtask

    task automatic expect_beat(input skdecode_pkg::sk_beat_t beat, input int base);
        exp_word_q.push_back(word_from_beat(beat, 0));
        exp_addr_q.push_back(skdecode_pkg::mem_addr_t'(base));
        exp_word_q.push_back(word_from_beat(beat, 1));
        exp_addr_q.push_back(skdecode_pkg::mem_addr_t'(base + 1));
    endtask

    // one full four-phase cycle, req stays up for hold extra cycles after ack
    task automatic send_beat(input skdecode_pkg::sk_beat_t beat, input int hold);
        @(posedge clk);
        #1;
        sk_data_i = beat;
        sk_req_i  = 1'b1;
        @(negedge clk);
        while (!sk_ack_o) @(negedge clk);
        repeat (hold) @(negedge clk);
        @(posedge clk);
        #1;
        sk_req_i = 1'b0;
        @(negedge clk);
        while (sk_ack_o) @(negedge clk);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #1;
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic drain_writes();
        while (exp_word_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    // writes are compared at the falling edge, where address and data are settled
    always @(negedge clk) begin
        if (rst_n_i && mem_we_o) begin
            if (exp_word_q.size() == 0) begin
                abort_run($sformatf("unexpected memory write at address %0d, time %0t",
                                    mem_addr_o, $time));
            end else begin
                check_addr("mem_addr_o", mem_addr_o, exp_addr_q.pop_front());
                check_word("mem_wdata_o", mem_wdata_o, exp_word_q.pop_front());
            end
        end
    end

    // ack may only rise while req is high and only fall once req is low
    // so a new ack can never come before req has dropped in between
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (ack_prev && !sk_ack_o && sk_req_i) begin
                abort_run("handshake error, ack dropped while req was still high");
            end
            if (!ack_prev && sk_ack_o && !sk_req_i) begin
                abort_run("handshake error, ack rose without a new req");
            end
            ack_prev = sk_ack_o;
        end
    end

    initial begin
        #(watchdog_cycles * 10);
        abort_run("watchdog expired, the DUT stopped acknowledging beats or writing words");
    end

    initial begin
        skdecode_pkg::sk_beat_t beat;
        int                     hold;
        int                     addr;

        rst_n_i      = 1'b0;
        start_i      = 1'b0;
        sk_req_i     = 1'b0;
        sk_data_i    = '0;
        rng_state    = 32'h3787;
        ack_prev     = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_flag("sk_ack_o", sk_ack_o, 1'b0);
        check_flag("mem_we_o", mem_we_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
        check_flag("error_o", error_o, 1'b0);

        // directed table, two words per beat at consecutive addresses
        fill_table();
        pulse_start();
        addr = 0;
        for (int r = 0; r < num_directed; r++) begin
            exp_word_q.push_back(dir_table[r].word_lo);
            exp_addr_q.push_back(skdecode_pkg::mem_addr_t'(addr));
            exp_word_q.push_back(dir_table[r].word_hi);
            exp_addr_q.push_back(skdecode_pkg::mem_addr_t'(addr + 1));
            addr = addr + 2;
            send_beat(dir_table[r].beat, int'(dir_table[r].hold));
        end
        drain_writes();
        check_flag("done_o", done_o, 1'b0);

        // full key, every word of s1 and s2
        pulse_start();
        check_addr("mem_addr_o", mem_addr_o, '0);
        for (int b = 0; b < num_random; b++) begin
            random_beat(beat);
            random_hold(hold);
            expect_beat(beat, 2 * b);
            send_beat(beat, hold);
        end
        drain_writes();
        while (!done_o) @(negedge clk);
        repeat (20) @(negedge clk);
        check_flag("done_o", done_o, 1'b1);
        check_flag("error_o", error_o, 1'b0);

        // bad fields 5, 6 and 7, each in a fresh run and followed by a valid beat
        // that must be dropped, so every bad value on its own has to raise the error
        for (int k = 0; k < 3; k++) begin
            pulse_start();
            check_flag("done_o", done_o, 1'b0);
            check_flag("error_o", error_o, 1'b0);
            random_beat(beat);
            beat[((3 * k + 2) % 8) * 3 +: 3] = 3'(5 + k);
            send_beat(beat, k);
            check_flag("error_o", error_o, 1'b1);
            random_beat(beat);
            send_beat(beat, 0);
        end
        repeat (20) @(negedge clk);
        check_flag("done_o", done_o, 1'b0);
        check_flag("error_o", error_o, 1'b1);

        // a new start clears the error and the next beat lands at address 0
        pulse_start();
        check_flag("error_o", error_o, 1'b0);
        check_addr("mem_addr_o", mem_addr_o, '0);
        random_beat(beat);
        expect_beat(beat, 0);
        send_beat(beat, 1);
        drain_writes();
        check_flag("error_o", error_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);

        $display("TEST PASSED");
        $finish;
    end

endmodule
